/* verilog/y86_pkg.sv */
`default_nettype none

package y86_pkg;

  // instruction codes, byte 0 high nibble
  localparam logic [3:0] I_HALT   = 4'h0;
  localparam logic [3:0] I_NOP    = 4'h1;
  localparam logic [3:0] I_RRMOVQ = 4'h2; // also cmovXX
  localparam logic [3:0] I_IRMOVQ = 4'h3;
  localparam logic [3:0] I_RMMOVQ = 4'h4;
  localparam logic [3:0] I_MRMOVQ = 4'h5;
  localparam logic [3:0] I_OPQ    = 4'h6;
  localparam logic [3:0] I_JXX    = 4'h7;
  localparam logic [3:0] I_CALL   = 4'h8;
  localparam logic [3:0] I_RET    = 4'h9;
  localparam logic [3:0] I_PUSHQ  = 4'ha;
  localparam logic [3:0] I_POPQ   = 4'hb;

  // alu functions for OPq
  localparam logic [3:0] F_ADD = 4'h0;
  localparam logic [3:0] F_SUB = 4'h1;
  localparam logic [3:0] F_AND = 4'h2;
  localparam logic [3:0] F_XOR = 4'h3;

  // condition functions for cmovXX and jXX
  localparam logic [3:0] C_YES = 4'h0;
  localparam logic [3:0] C_LE  = 4'h1;
  localparam logic [3:0] C_L   = 4'h2;
  localparam logic [3:0] C_E   = 4'h3;
  localparam logic [3:0] C_NE  = 4'h4;
  localparam logic [3:0] C_GE  = 4'h5;
  localparam logic [3:0] C_G   = 4'h6;

  // status, zero never used
  localparam logic [2:0] S_AOK = 3'd1;
  localparam logic [2:0] S_HLT = 3'd2;
  localparam logic [2:0] S_ADR = 3'd3;
  localparam logic [2:0] S_INS = 3'd4;

  localparam logic [3:0] R_RSP  = 4'h4;
  localparam logic [3:0] R_NONE = 4'hf;

  // host map, memory bytes start at 0
  localparam logic [15:0] A_CTRL     = 16'h1000;
  localparam logic [15:0] A_PC       = 16'h1004;
  localparam logic [15:0] A_REG_BASE = 16'h1100;

endpackage

`default_nettype wire

/* verilog/y86_fetch_pc.sv */
`default_nettype none

module y86_fetch_pc
  import y86_pkg::*;
#(
  parameter int MEM_BYTES = 1024
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  input  logic        pc_load,
  input  logic [63:0] pc_wdata,
  input  logic [79:0] imem_bytes,
  input  logic        cnd,
  input  logic [63:0] valM,
  output logic [63:0] pc,
  output logic [3:0]  icode,
  output logic [3:0]  ifun,
  output logic [3:0]  rA,
  output logic [3:0]  rB,
  output logic [63:0] valC,
  output logic [63:0] valP,
  output logic        instr_valid,
  output logic        imem_error
);

  localparam logic [63:0] PC_MAX = 64'(MEM_BYTES - 10); // last pc with a full window

  logic need_regids;
  logic need_valc;
  logic [63:0] next_pc;

  assign icode = imem_bytes[7:4];
  assign ifun  = imem_bytes[3:0];

  assign need_regids = (icode == I_RRMOVQ) || (icode == I_IRMOVQ) || (icode == I_RMMOVQ) ||
                       (icode == I_MRMOVQ) || (icode == I_OPQ) || (icode == I_PUSHQ) ||
                       (icode == I_POPQ);
  assign need_valc = (icode == I_IRMOVQ) || (icode == I_RMMOVQ) || (icode == I_MRMOVQ) ||
                     (icode == I_JXX) || (icode == I_CALL);

  assign rA = need_regids ? imem_bytes[15:12] : R_NONE;
  assign rB = need_regids ? imem_bytes[11:8] : R_NONE;

  // constant follows the register byte when there is one
  assign valC = !need_valc ? 64'd0 : (need_regids ? imem_bytes[79:16] : imem_bytes[71:8]);
  assign valP = pc + 64'd1 + (need_regids ? 64'd1 : 64'd0) + (need_valc ? 64'd8 : 64'd0);

  always_comb
  begin
    case (icode)
      I_OPQ:            instr_valid = (ifun <= F_XOR);
      I_RRMOVQ, I_JXX:  instr_valid = (ifun <= C_G);
      default:          instr_valid = (icode <= I_POPQ) && (ifun == 4'h0);
    endcase
  end

  assign imem_error = (pc > PC_MAX);

  always_comb
  begin
    case (icode)
      I_CALL:  next_pc = valC;
      I_JXX:   next_pc = cnd ? valC : valP;
      I_RET:   next_pc = valM; // return address popped off the stack
      default: next_pc = valP;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= 64'd0;
    else if (pc_load)
      pc <= pc_wdata;
    else if (step)
      pc <= next_pc;
  end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`default_nettype none

module register_file
  import y86_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  input  logic [3:0]  icode,
  input  logic [3:0]  rA,
  input  logic [3:0]  rB,
  input  logic        cnd,
  input  logic [63:0] valE,
  input  logic [63:0] valM,
  input  logic [3:0]  dbg_sel,
  output logic [63:0] valA,
  output logic [63:0] valB,
  output logic [63:0] dbg_val
);

  logic [63:0] reg_mem [0:14];
  logic [3:0]  src_a;
  logic [3:0]  src_b;
  logic [3:0]  dst_e;
  logic [3:0]  dst_m;

  // decode, source registers per icode
  always_comb
  begin
    src_a = R_NONE;
    src_b = R_NONE;
    case (icode)
      I_RRMOVQ: src_a = rA;
      I_RMMOVQ, I_OPQ:
      begin
        src_a = rA;
        src_b = rB;
      end
      I_MRMOVQ: src_b = rB;
      I_CALL:   src_b = R_RSP;
      I_RET, I_POPQ:
      begin
        src_a = R_RSP;
        src_b = R_RSP;
      end
      I_PUSHQ:
      begin
        src_a = rA;
        src_b = R_RSP;
      end
      default: ;
    endcase
  end

  assign valA    = (src_a == R_NONE) ? 64'd0 : reg_mem[src_a];
  assign valB    = (src_b == R_NONE) ? 64'd0 : reg_mem[src_b];
  assign dbg_val = (dbg_sel == R_NONE) ? 64'd0 : reg_mem[dbg_sel];

  // write-back destinations
  always_comb
  begin
    dst_e = R_NONE;
    dst_m = R_NONE;
    case (icode)
      I_RRMOVQ:              dst_e = cnd ? rB : R_NONE; // cmov not taken
      I_IRMOVQ, I_OPQ:       dst_e = rB;
      I_MRMOVQ:              dst_m = rA;
      I_CALL, I_RET, I_PUSHQ: dst_e = R_RSP;
      I_POPQ:
      begin
        dst_e = R_RSP;
        dst_m = rA;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 15; i++)
        reg_mem[i] <= 64'(i);
    end
    else if (step)
    begin
      if (dst_e != R_NONE)
        reg_mem[dst_e] <= valE;
      if (dst_m != R_NONE)
        reg_mem[dst_m] <= valM; // last, so popq %rsp keeps valM
    end
  end

endmodule

`default_nettype wire

/* verilog/y86_execute.sv */
`default_nettype none

module y86_execute
  import y86_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  input  logic [3:0]  icode,
  input  logic [3:0]  ifun,
  input  logic [63:0] valA,
  input  logic [63:0] valB,
  input  logic [63:0] valC,
  output logic [63:0] valE,
  output logic        cnd
);

  logic [63:0] alu_a;
  logic [63:0] alu_b;
  logic [3:0]  alu_fun;
  logic        ovf;
  logic        zf;
  logic        sf;
  logic        of;
  logic        lt;

  // operand select, result is alu_b op alu_a
  always_comb
  begin
    alu_a   = 64'd0;
    alu_b   = 64'd0;
    alu_fun = F_ADD;
    case (icode)
      I_RRMOVQ:         alu_a = valA;
      I_IRMOVQ:         alu_a = valC;
      I_RMMOVQ, I_MRMOVQ:
      begin
        alu_a = valC; // displacement
        alu_b = valB;
      end
      I_OPQ:
      begin
        alu_a   = valA;
        alu_b   = valB;
        alu_fun = ifun;
      end
      I_CALL, I_PUSHQ:
      begin
        alu_a   = 64'd8;
        alu_b   = valB;
        alu_fun = F_SUB;
      end
      I_RET, I_POPQ:
      begin
        alu_a = 64'd8;
        alu_b = valB;
      end
      default: ;
    endcase
  end

  always_comb
  begin
    case (alu_fun)
      F_SUB:   valE = alu_b - alu_a;
      F_AND:   valE = alu_b & alu_a;
      F_XOR:   valE = alu_b ^ alu_a;
      default: valE = alu_b + alu_a;
    endcase
  end

  // signed overflow, only add and sub can set it
  assign ovf = (alu_fun == F_ADD) ? (alu_a[63] == alu_b[63]) && (valE[63] != alu_b[63]) :
               (alu_fun == F_SUB) ? (alu_a[63] != alu_b[63]) && (valE[63] != alu_b[63]) :
               1'b0;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      zf <= 1'b1;
      sf <= 1'b0;
      of <= 1'b0;
    end
    else if (step && icode == I_OPQ)
    begin
      zf <= (valE == 64'd0);
      sf <= valE[63];
      of <= ovf;
    end
  end

  assign lt = sf ^ of;

  always_comb
  begin
    cnd = 1'b0;
    if (icode == I_RRMOVQ || icode == I_JXX)
    begin
      case (ifun)
        C_YES:   cnd = 1'b1;
        C_LE:    cnd = lt | zf;
        C_L:     cnd = lt;
        C_E:     cnd = zf;
        C_NE:    cnd = !zf;
        C_GE:    cnd = !lt;
        C_G:     cnd = !lt && !zf;
        default: cnd = 1'b0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/y86_memory.sv */
`default_nettype none

module y86_memory
  import y86_pkg::*;
#(
  parameter int MEM_BYTES = 1024
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  input  logic [3:0]  icode,
  input  logic [63:0] valE,
  input  logic [63:0] valA,
  input  logic [63:0] valP,
  input  logic [63:0] pc,
  input  logic        host_we,
  input  logic [15:0] host_addr,
  input  logic [7:0]  host_wdata,
  output logic [79:0] imem_bytes,
  output logic [63:0] valM,
  output logic        dmem_error,
  output logic [7:0]  host_rdata
);

  localparam int AW = $clog2(MEM_BYTES);
  localparam logic [63:0] ADDR_MAX = 64'(MEM_BYTES - 8); // last full 8-byte slot

  logic [7:0]  mem [MEM_BYTES];
  logic [63:0] daddr;
  logic [63:0] wdata;
  logic        mem_read;
  logic        mem_write;

  assign mem_read  = (icode == I_MRMOVQ) || (icode == I_RET) || (icode == I_POPQ);
  assign mem_write = (icode == I_RMMOVQ) || (icode == I_CALL) || (icode == I_PUSHQ);
  assign daddr     = (icode == I_RET || icode == I_POPQ) ? valA : valE; // pops read old rsp
  assign wdata     = (icode == I_CALL) ? valP : valA;
  assign dmem_error = (mem_read || mem_write) && (daddr > ADDR_MAX);

  // little-endian windows, index wraps, range flagged separately
  always_comb
  begin
    for (int k = 0; k < 10; k++)
      imem_bytes[8*k +: 8] = mem[pc[AW-1:0] + AW'(k)];
    for (int k = 0; k < 8; k++)
      valM[8*k +: 8] = mem[daddr[AW-1:0] + AW'(k)];
  end

  assign host_rdata = mem[host_addr[AW-1:0]];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < MEM_BYTES; i++)
        mem[i] <= 8'd0;
    end
    else if (step && mem_write)
    begin
      for (int k = 0; k < 8; k++)
        mem[daddr[AW-1:0] + AW'(k)] <= wdata[8*k +: 8];
    end
    else if (host_we)
      mem[host_addr[AW-1:0]] <= host_wdata;
  end

endmodule

`default_nettype wire

/* verilog/y86_core_top.sv */
`default_nettype none

module y86_core_top
  import y86_pkg::*;
#(
  parameter int MEM_BYTES = 1024
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [15:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic        run;
  logic [2:0]  stat;
  logic        running;
  logic        step;
  logic        access;
  logic        mem_hit, ctrl_hit, pc_hit, reg_hit;
  logic [15:0] reg_off;
  logic [63:0] pc, valC, valP, valA, valB, valE, valM, dbg_val;
  logic [79:0] imem_bytes;
  logic [7:0]  host_rdata;
  logic [3:0]  icode, ifun, rA, rB;
  logic        instr_valid, imem_error, dmem_error, cnd;

  assign access   = psel && penable;
  assign reg_off  = paddr - A_REG_BASE;
  assign mem_hit  = (32'(paddr) < MEM_BYTES);
  assign ctrl_hit = (paddr == A_CTRL);
  assign pc_hit   = (paddr == A_PC);
  assign reg_hit  = (paddr >= A_REG_BASE) && (reg_off < 16'd120) && (paddr[1:0] == 2'b00);

  assign pready  = 1'b1; // zero wait states
  assign pslverr = access && (!(mem_hit || ctrl_hit || pc_hit || reg_hit) ||
                              (pwrite && run && !ctrl_hit));

  always_comb
  begin
    prdata = 32'd0;
    if (mem_hit)
      prdata = {24'd0, host_rdata};
    else if (ctrl_hit)
      prdata = {25'd0, stat, 3'd0, run};
    else if (pc_hit)
      prdata = pc[31:0];
    else if (reg_hit)
      prdata = reg_off[2] ? dbg_val[63:32] : dbg_val[31:0];
  end

  // commit only when nothing stops the instruction
  assign running = run && (stat == S_AOK);
  assign step = running && !imem_error && instr_valid && (icode != I_HALT) && !dmem_error;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      run  <= 1'b0;
      stat <= S_AOK;
    end
    else if (access && pwrite && ctrl_hit)
    begin
      run <= pwdata[0];
      if (pwdata[0])
        stat <= S_AOK;
    end
    else if (running && !step)
    begin
      run <= 1'b0;
      if (imem_error)
        stat <= S_ADR;
      else if (!instr_valid)
        stat <= S_INS;
      else if (icode == I_HALT)
        stat <= S_HLT;
      else
        stat <= S_ADR; // data address out of range
    end
  end

  y86_fetch_pc #(.MEM_BYTES(MEM_BYTES)) u_fetch (
    .clk(clk), .reset(reset), .step(step),
    .pc_load(access && pwrite && pc_hit && !run), .pc_wdata({32'd0, pwdata}),
    .imem_bytes(imem_bytes), .cnd(cnd), .valM(valM), .pc(pc),
    .icode(icode), .ifun(ifun), .rA(rA), .rB(rB), .valC(valC), .valP(valP),
    .instr_valid(instr_valid), .imem_error(imem_error)
  );

  register_file u_regs (
    .clk(clk), .reset(reset), .step(step), .icode(icode), .rA(rA), .rB(rB),
    .cnd(cnd), .valE(valE), .valM(valM), .dbg_sel(reg_off[6:3]),
    .valA(valA), .valB(valB), .dbg_val(dbg_val)
  );

  y86_execute u_exec (
    .clk(clk), .reset(reset), .step(step), .icode(icode), .ifun(ifun),
    .valA(valA), .valB(valB), .valC(valC), .valE(valE), .cnd(cnd)
  );

  y86_memory #(.MEM_BYTES(MEM_BYTES)) u_mem (
    .clk(clk), .reset(reset), .step(step), .icode(icode),
    .valE(valE), .valA(valA), .valP(valP), .pc(pc),
    .host_we(access && pwrite && mem_hit && !run), .host_addr(paddr),
    .host_wdata(pwdata[7:0]), .imem_bytes(imem_bytes), .valM(valM),
    .dmem_error(dmem_error), .host_rdata(host_rdata)
  );

endmodule

`default_nettype wire

/* dv/y86_sva.sv */
`default_nettype none

module y86_sva
  import y86_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [15:0] paddr,
  input logic        run,
  input logic [2:0]  stat,
  input logic [63:0] pc,
  input logic        step
);

  timeunit 1ns;
  timeprecision 1ps;

  int fails = 0;

  a_stat: assert property (@(posedge clk) disable iff (reset) stat != 3'd0)
    else
    begin
      fails++;
      $error("stat holds zero");
    end

  a_run: assert property (@(posedge clk) disable iff (reset) (stat != S_AOK) |-> !run)
    else
    begin
      fails++;
      $error("run set with a stop status");
    end

  // host pc write is the only other way pc moves
  a_pc: assert property (@(posedge clk) disable iff (reset)
      (!step && !(psel && penable && pwrite && paddr == A_PC && !run)) |=> $stable(pc))
    else
    begin
      fails++;
      $error("pc changed without a step");
    end

endmodule

bind y86_core_top y86_sva u_sva (
  .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
  .paddr(paddr), .run(run), .stat(stat), .pc(pc), .step(step)
);

`default_nettype wire

/* dv/y86_checker.sv */
`default_nettype none

module y86_checker (
  input logic        clk,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [15:0] paddr,
  input logic [31:0] prdata,
  input logic        pready,
  input logic        pslverr
);

  timeunit 1ns;
  timeprecision 1ps;

  // one entry per expected access in bus order
  bit          cmp_q[$];
  logic [31:0] data_q[$];
  bit          err_q[$];

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_errors = 0;

  bit          cmp;
  bit          err;
  logic [31:0] exp_data;

  task automatic expect_access(input bit c, input logic [31:0] d, input bit e);
    cmp_q.push_back(c);
    data_q.push_back(d);
    err_q.push_back(e);
  endtask

  task automatic count_failure(input string what);
    $display("%s", what);
    errors++;
    test_errors++;
  endtask

  task automatic end_test();
    tests++;
    if (test_errors == 0)
      $display("test %0d passed", tests);
    else
      $display("test %0d failed with %0d errors", tests, test_errors);
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("%0d tests, %0d checked reads, %0d errors", tests, checks, errors);
  endtask

  always @(negedge clk)
  begin
    if (psel && penable)
    begin
      if (!pready)
        count_failure($sformatf("pready low during access to %h", paddr));
      if (cmp_q.size() == 0)
        count_failure($sformatf("bus access to %h with nothing expected", paddr));
      else
      begin
        cmp = cmp_q.pop_front();
        exp_data = data_q.pop_front();
        err = err_q.pop_front();
        if (err && !pslverr)
          count_failure($sformatf("pslverr missing on rejected access to %h", paddr));
        else if (!err && pslverr)
          count_failure($sformatf("pslverr raised on legal access to %h", paddr));
        if (cmp && !pwrite)
        begin
          checks++;
          if (prdata !== exp_data)
          begin
            $display("Error %0t: read %h expected %h got %h", $time, paddr, exp_data, prdata);
            errors++;
            test_errors++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/y86_tb.sv */
`default_nettype none

module y86_tb
  import y86_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  integer seed;
  string  lines[$];
  int     watchdog_cycles;
  bit     limit_ready;

  y86_core_top #(.MEM_BYTES(1024)) UUT (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  y86_checker chk (
    .clk(clk), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // setup phase, access phase, then a few random idle cycles
  task automatic apb_access(input bit wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int idle;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata; // stable mid access
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    idle = $random(seed) & 3;
    repeat (idle) @(posedge clk);
  endtask

  task automatic write_ok(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    chk.expect_access(1'b0, 32'd0, 1'b0);
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic write_rejected(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    chk.expect_access(1'b0, 32'd0, 1'b1);
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [31:0] expected);
    logic [31:0] unused;
    chk.expect_access(1'b1, expected, 1'b0);
    apb_access(1'b0, addr, 32'd0, unused);
  endtask

  task automatic read_rejected(input logic [15:0] addr);
    logic [31:0] unused;
    chk.expect_access(1'b0, 32'd0, 1'b1);
    apb_access(1'b0, addr, 32'd0, unused);
  endtask

  task automatic run_and_poll();
    logic [31:0] ctrl;
    write_ok(A_CTRL, 32'd1);
    do
    begin
      chk.expect_access(1'b0, 32'd0, 1'b0);
      apb_access(1'b0, A_CTRL, 32'd0, ctrl);
    end
    while (ctrl[0]);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic do_line(input string line);
    byte         cmd;
    logic [63:0] a;
    logic [63:0] d;
    logic [15:0] addr;
    logic [15:0] reg_addr;
    int          n;
    a = 64'd0;
    d = 64'd0;
    n = $sscanf(line, "%c %h %h", cmd, a, d);
    if (n != 3)
    begin
      chk.count_failure($sformatf("malformed vector line: %s", line));
      return;
    end
    addr = a[15:0];
    reg_addr = A_REG_BASE + {addr[12:0], 3'b000};
    case (cmd)
      "L":
        for (int k = 0; k < 8; k++)
          write_ok(addr + 16'(k), {24'd0, d[8*k +: 8]}); // little-endian bytes
      "P": write_ok(A_PC, d[31:0]);
      "R": run_and_poll();
      "T": write_ok(A_CTRL, 32'd1);
      "H": write_ok(A_CTRL, 32'd0);
      "G":
      begin
        read_check(reg_addr, d[31:0]);
        read_check(reg_addr + 16'd4, d[63:32]);
      end
      "M": read_check(addr, {24'd0, d[7:0]});
      "S": read_check(A_CTRL, {25'd0, d[2:0], 4'd0}); // run bit expected clear
      "X": write_rejected(addr, d[31:0]);
      "Y": read_rejected(addr);
      "E":
      begin
        chk.end_test();
        apply_reset();
      end
      default: chk.count_failure($sformatf("unknown vector command in line: %s", line));
    endcase
  endtask

  initial
  begin
    int    fd;
    string line;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 16'd0;
    pwdata  = 32'd0;
    seed    = 32'h0f0f_e35c;
    fd = $fopen("dv/y86_vectors.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        if ($fgets(line, fd) != 0)
          lines.push_back(line);
      end
      $fclose(fd);
    end
    if (lines.size() == 0)
      chk.count_failure("vector file dv/y86_vectors.txt missing or empty");
    watchdog_cycles = lines.size() * 64 + 2000;
    limit_ready = 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    foreach (lines[i])
    begin
      if (lines[i].len() < 2 || lines[i].getc(0) == "#")
        continue;
      do_line(lines[i]);
    end
    chk.report_counts();
    if (chk.errors == 0 && UUT.u_sva.fails == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // watchdog
  initial
  begin
    wait (limit_ready);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: vectors did not finish within %0d clock cycles", watchdog_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/y86_vectors.txt */
# cmd addr data, hex. L load 8 bytes little-endian, P set pc, R run and poll, T start, H stop
# G reg value, M addr byte, S 0 stat, X write rejected, Y read rejected, E end test and reset
G 0 0
G 4 4
G e e
S 0 1
E 0 0
L 0 000000001234f830
L 8 21619a6089200000
L 10 000000008c638b62
R 0 0
G 8 1234
G 9 1234
G a 123e
G 1 ffffffffffffffff
G b 0
G c 1238
S 0 2
E 0 0
L 0 3a26392308222161
L 8 0000000014723b24
L 10 0000287500000000
L 18 55fc300000000000
L 28 000000000066fd30
R 0 0
G 1 ffffffffffffffff
G 8 0
G 9 9
G a a
G b 3
G c 55
G d d
S 0 2
E 0 0
L 0 000000000200f430
L 8 55667788f0300000
L 10 0100034011223344
L 18 7350000000000000
L 20 0000000000000100
L 28 0000000040800fa0
L 30 0000004fb0000000
L 40 000000000077fe30
L 48 0000000000900000
R 0 0
G 7 1122334455667788
G 4 1122334455667788
G e 77
M 103 88
M 10a 11
M 1f0 33
M 1f1 0
M 1f8 88
S 0 2
E 0 0
L 0 c010
R 0 0
S 0 4
G 0 0
E 0 0
L 0 0000000004000f50
R 0 0
S 0 3
G 0 0
E 0 0
L 0 00000000003fc70
R 0 0
S 0 3
E 0 0
L 0 70
T 0 0
X 80 5a
X 1004 40
Y 2000 0
H 0 0
M 80 0
S 0 1
Y 1003 0
E 0 0

/* compile.f */
verilog/y86_pkg.sv
verilog/y86_fetch_pc.sv
verilog/register_file.sv
verilog/y86_execute.sv
verilog/y86_memory.sv
verilog/y86_core_top.sv
dv/y86_sva.sv
dv/y86_checker.sv
dv/y86_tb.sv

/* run_sim.sh */
#!/bin/bash
# build and run the Y86 testbench with Verilator, then scan the log
verilator --binary -f compile.f --top y86_tb -o y86_sim \
  && ./obj_dir/y86_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
! grep -q "Done: errors found" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
